// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_icache
FILELIST := list.f
BUILD    := obj_dir
RUNARGS  := +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNARGS)

clean:
	rm -rf $(BUILD)

// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    // beats minus one
    typedef logic [7:0] axi_len_t;
    typedef logic [1:0] axi_burst_t;

    typedef enum logic [1:0] {
        AXI_IDLE,
        AXI_ADDR,
        AXI_DATA,
        AXI_ACK
    } axi_state_e;

endpackage

`default_nettype wire

// ==== icache_axi_read.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_axi_read (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              rd_req,
    input  wire icache_pkg::addr_t rd_addr,
    input  wire axi_pkg::axi_len_t rd_len,
    input  wire logic              arready,
    input  wire icache_pkg::word_t rdata,
    input  wire logic              rlast,
    input  wire logic              rvalid,
    output logic                   rd_ack,
    output logic                   beat_valid,
    output icache_pkg::word_t      beat_data,
    output icache_pkg::offset_t    beat_offset,
    output icache_pkg::addr_t      araddr,
    output axi_pkg::axi_len_t      arlen,
    output axi_pkg::axi_burst_t    arburst,
    output logic                   arvalid,
    output logic                   rready
);

    axi_pkg::axi_state_e state;
    icache_pkg::offset_t beat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= axi_pkg::AXI_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                axi_pkg::AXI_IDLE: begin
                    beat_cnt <= '0;
                    if (rd_req) begin
                        state <= axi_pkg::AXI_ADDR;
                    end
                end
                axi_pkg::AXI_ADDR: begin
                    if (arready) begin
                        state <= axi_pkg::AXI_DATA;
                    end
                end
                axi_pkg::AXI_DATA: begin
                    if (rvalid) begin
                        beat_cnt <= beat_cnt + icache_pkg::offset_t'(1);
                        if (rlast) begin
                            state <= axi_pkg::AXI_ACK;
                        end
                    end
                end
                // hold ack until the requester lets go
                default: begin
                    if (!rd_req) begin
                        state <= axi_pkg::AXI_IDLE;
                    end
                end
            endcase
        end
    end

    // address fields come straight from the held request
    assign arvalid = state == axi_pkg::AXI_ADDR;
    assign araddr  = rd_addr;
    assign arlen   = rd_len;
    assign arburst = (rd_len == '0) ? `AXI_BURST_FIXED : `AXI_BURST_INCR;

    assign rready      = state == axi_pkg::AXI_DATA;
    assign beat_valid  = rready && rvalid;
    assign beat_data   = rdata;
    assign beat_offset = beat_cnt;
    assign rd_ack      = state == axi_pkg::AXI_ACK;

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_ctrl (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                inst_req,
    input  wire icache_pkg::addr_t   inst_addr,
    input  wire logic                hit,
    input  wire icache_pkg::way_t    hit_way,
    input  wire icache_pkg::word_t   hit_word,
    input  wire icache_pkg::way_t    victim,
    input  wire logic                rd_ack,
    input  wire logic                beat_valid,
    input  wire icache_pkg::word_t   beat_data,
    input  wire icache_pkg::offset_t beat_offset,
    output logic                     inst_data_ok,
    output icache_pkg::word_t        inst_rdata,
    output icache_pkg::index_t       look_index,
    output icache_pkg::tag_t         look_tag,
    output icache_pkg::offset_t      look_offset,
    output logic                     tag_we,
    output logic                     data_we,
    output icache_pkg::way_t         wr_way,
    output logic                     touch,
    output icache_pkg::way_t         touch_way,
    output logic                     rd_req,
    output icache_pkg::addr_t        rd_addr,
    output axi_pkg::axi_len_t        rd_len
);

    icache_pkg::ctrl_state_e state;
    icache_pkg::addr_t       addr_r;
    icache_pkg::addr_t       mapped_addr;
    icache_pkg::word_t       reply_r;
    logic                    uncached_r;
    logic                    req_uncached;
    logic                    take_beat;

    assign req_uncached = inst_addr[`ADDR_W-1 -: 3] == `SEG_UNCACHED;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= icache_pkg::CTRL_IDLE;
            uncached_r <= 1'b0;
        end else begin
            case (state)
                icache_pkg::CTRL_IDLE: begin
                    if (inst_req) begin
                        uncached_r <= req_uncached;
                        state      <= req_uncached ? icache_pkg::CTRL_UNCACHED
                                                   : icache_pkg::CTRL_LOOKUP;
                    end
                end
                icache_pkg::CTRL_LOOKUP: begin
                    state <= hit ? icache_pkg::CTRL_IDLE : icache_pkg::CTRL_REFILL;
                end
                icache_pkg::CTRL_REFILL: begin
                    if (rd_ack) begin
                        state <= icache_pkg::CTRL_UPDATE;
                    end
                end
                icache_pkg::CTRL_UNCACHED: begin
                    if (rd_ack) begin
                        state <= icache_pkg::CTRL_RESPOND;
                    end
                end
                icache_pkg::CTRL_UPDATE: state <= icache_pkg::CTRL_RESPOND;
                default: state <= icache_pkg::CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == icache_pkg::CTRL_IDLE && inst_req) begin
            addr_r <= inst_addr;
        end
    end

    // single uncached beat always lands at offset 0
    assign take_beat = beat_valid && (uncached_r || beat_offset == look_offset);

    always_ff @(posedge clk) begin
        if (take_beat) begin
            reply_r <= beat_data;
        end
    end

    assign look_offset = addr_r[2 +: $bits(icache_pkg::offset_t)];
    assign look_index  = addr_r[2 + $bits(icache_pkg::offset_t) +: $bits(icache_pkg::index_t)];
    assign look_tag    = addr_r[`ADDR_W-1 -: $bits(icache_pkg::tag_t)];

    // kseg0/kseg1 style strip of the segment bits
    assign mapped_addr = (addr_r[`ADDR_W-1 -: 3] == `SEG_UNCACHED ||
                          addr_r[`ADDR_W-1 -: 3] == `SEG_MAPPED_LO) ?
                         {3'b000, addr_r[`ADDR_W-4:0]} : addr_r;

    assign rd_req  = state == icache_pkg::CTRL_REFILL || state == icache_pkg::CTRL_UNCACHED;
    assign rd_addr = uncached_r ? mapped_addr
                   : mapped_addr & ~icache_pkg::addr_t'(`ICACHE_LINE_WORDS * 4 - 1);
    assign rd_len  = uncached_r ? '0 : axi_pkg::axi_len_t'(`ICACHE_LINE_WORDS - 1);

    assign data_we   = state == icache_pkg::CTRL_REFILL && beat_valid;
    assign tag_we    = state == icache_pkg::CTRL_UPDATE;
    assign wr_way    = victim;
    assign touch     = (state == icache_pkg::CTRL_LOOKUP && hit) || tag_we;
    assign touch_way = (state == icache_pkg::CTRL_LOOKUP) ? hit_way : victim;

    assign inst_data_ok = (state == icache_pkg::CTRL_LOOKUP && hit) ||
                          state == icache_pkg::CTRL_RESPOND;
    assign inst_rdata   = (state == icache_pkg::CTRL_LOOKUP) ? hit_word : reply_r;

endmodule

`default_nettype wire

// ==== icache_data_array.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_data_array (
    input  wire logic                clk,
    input  wire icache_pkg::index_t  look_index,
    input  wire icache_pkg::offset_t look_offset,
    input  wire icache_pkg::way_t    hit_way,
    input  wire logic                data_we,
    input  wire icache_pkg::way_t    wr_way,
    input  wire icache_pkg::offset_t beat_offset,
    input  wire icache_pkg::word_t   beat_data,
    output icache_pkg::word_t        hit_word
);

    icache_pkg::word_t lines [`ICACHE_WAYS][`ICACHE_SETS][`ICACHE_LINE_WORDS];

    // one refill beat per cycle
    always_ff @(posedge clk) begin
        if (data_we) begin
            lines[wr_way][look_index][beat_offset] <= beat_data;
        end
    end

    assign hit_word = lines[hit_way][look_index][look_offset];

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none
`include "icache_settings.svh"

package icache_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [$clog2(`ICACHE_SETS)-1:0]       index_t;
    typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] offset_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0]       way_t;

    // whatever is left above index, offset and byte bits
    typedef logic [`ADDR_W-$clog2(`ICACHE_SETS)-$clog2(`ICACHE_LINE_WORDS)-3:0] tag_t;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_REFILL,
        CTRL_UNCACHED,
        CTRL_UPDATE,
        CTRL_RESPOND
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== icache_plru.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_plru (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire icache_pkg::index_t look_index,
    input  wire logic               touch,
    input  wire icache_pkg::way_t   touch_way,
    output icache_pkg::way_t        victim
);

    // root picks the pair, lo/hi pick within ways 0-1 and 2-3
    logic [`ICACHE_SETS-1:0] root_bits;
    logic [`ICACHE_SETS-1:0] lo_bits;
    logic [`ICACHE_SETS-1:0] hi_bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            root_bits <= '0;
            lo_bits   <= '0;
            hi_bits   <= '0;
        end else if (touch) begin
            // point away from the way just used
            root_bits[look_index] <= ~touch_way[1];
            if (touch_way[1]) begin
                hi_bits[look_index] <= ~touch_way[0];
            end else begin
                lo_bits[look_index] <= ~touch_way[0];
            end
        end
    end

    assign victim = root_bits[look_index] ? {1'b1, hi_bits[look_index]}
                                          : {1'b0, lo_bits[look_index]};

endmodule

`default_nettype wire

// ==== icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry
`define ICACHE_WAYS       4
`define ICACHE_SETS       128
`define ICACHE_LINE_WORDS 8

`define ADDR_W 32
`define WORD_W 32

// top three address bits
`define SEG_UNCACHED  3'b101
`define SEG_MAPPED_LO 3'b100

// arburst encodings
`define AXI_BURST_FIXED 2'b00
`define AXI_BURST_INCR  2'b01

`endif

// ==== icache_tag_array.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_tag_array (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire icache_pkg::index_t look_index,
    input  wire icache_pkg::tag_t   look_tag,
    input  wire logic               tag_we,
    input  wire icache_pkg::way_t   wr_way,
    output logic                    hit,
    output icache_pkg::way_t        hit_way
);

    icache_pkg::tag_t                             tags [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_bits;

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[wr_way][look_index] <= look_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (tag_we) begin
            valid_bits[wr_way][look_index] <= 1'b1;
        end
    end

    // all ways compared in parallel
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (valid_bits[w][look_index] && tags[w][look_index] == look_tag) begin
                hit     = 1'b1;
                hit_way = icache_pkg::way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none

module icache_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              inst_req,
    input  wire icache_pkg::addr_t inst_addr,
    input  wire logic              arready,
    input  wire icache_pkg::word_t rdata,
    input  wire logic              rlast,
    input  wire logic              rvalid,
    output logic                   inst_data_ok,
    output icache_pkg::word_t      inst_rdata,
    output icache_pkg::addr_t      araddr,
    output axi_pkg::axi_len_t      arlen,
    output axi_pkg::axi_burst_t    arburst,
    output logic                   arvalid,
    output logic                   rready
);

    icache_pkg::index_t  look_index;
    icache_pkg::tag_t    look_tag;
    icache_pkg::offset_t look_offset;
    icache_pkg::way_t    hit_way;
    icache_pkg::way_t    victim;
    icache_pkg::way_t    wr_way;
    icache_pkg::way_t    touch_way;
    icache_pkg::word_t   hit_word;
    icache_pkg::word_t   beat_data;
    icache_pkg::offset_t beat_offset;
    icache_pkg::addr_t   rd_addr;
    axi_pkg::axi_len_t   rd_len;
    logic                hit;
    logic                tag_we;
    logic                data_we;
    logic                touch;
    logic                rd_req;
    logic                rd_ack;
    logic                beat_valid;

    icache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_addr(inst_addr),
        .hit(hit), .hit_way(hit_way), .hit_word(hit_word), .victim(victim),
        .rd_ack(rd_ack), .beat_valid(beat_valid), .beat_data(beat_data),
        .beat_offset(beat_offset), .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .look_index(look_index), .look_tag(look_tag), .look_offset(look_offset),
        .tag_we(tag_we), .data_we(data_we), .wr_way(wr_way), .touch(touch),
        .touch_way(touch_way), .rd_req(rd_req), .rd_addr(rd_addr), .rd_len(rd_len)
    );

    icache_tag_array u_tags (
        .clk(clk), .rst(rst), .look_index(look_index), .look_tag(look_tag),
        .tag_we(tag_we), .wr_way(wr_way), .hit(hit), .hit_way(hit_way)
    );

    icache_data_array u_data (
        .clk(clk), .look_index(look_index), .look_offset(look_offset), .hit_way(hit_way),
        .data_we(data_we), .wr_way(wr_way), .beat_offset(beat_offset),
        .beat_data(beat_data), .hit_word(hit_word)
    );

    icache_plru u_plru (
        .clk(clk), .rst(rst), .look_index(look_index), .touch(touch),
        .touch_way(touch_way), .victim(victim)
    );

    icache_axi_read u_axi_read (
        .clk(clk), .rst(rst), .rd_req(rd_req), .rd_addr(rd_addr), .rd_len(rd_len),
        .arready(arready), .rdata(rdata), .rlast(rlast), .rvalid(rvalid),
        .rd_ack(rd_ack), .beat_valid(beat_valid), .beat_data(beat_data),
        .beat_offset(beat_offset), .araddr(araddr), .arlen(arlen), .arburst(arburst),
        .arvalid(arvalid), .rready(rready)
    );

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
axi_pkg.sv
icache_pkg.sv
icache_ctrl.sv
icache_tag_array.sv
icache_data_array.sv
icache_plru.sv
icache_axi_read.sv
icache_top.sv
tb_icache_assert.sv
tb_icache.sv

// ==== tb_icache.sv ====
`default_nettype none
`include "icache_settings.svh"

module tb_icache;
    timeunit 1ns;
    timeprecision 100ps;

    // full sequence takes about 300 cycles even with long bus gaps
    localparam int TIMEOUT_CYCLES = 2000;

    logic                clk;
    logic                rst;
    logic                inst_req;
    icache_pkg::addr_t   inst_addr;
    logic                arready;
    icache_pkg::word_t   rdata;
    logic                rlast;
    logic                rvalid;
    logic                inst_data_ok;
    icache_pkg::word_t   inst_rdata;
    icache_pkg::addr_t   araddr;
    axi_pkg::axi_len_t   arlen;
    axi_pkg::axi_burst_t arburst;
    logic                arvalid;
    logic                rready;

    logic [15:0] lfsr_state = 16'd81;
    int          cycle_count = 0;

    icache_top DUT (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_addr(inst_addr),
        .arready(arready), .rdata(rdata), .rlast(rlast), .rvalid(rvalid),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata), .araddr(araddr),
        .arlen(arlen), .arburst(arburst), .arvalid(arvalid), .rready(rready)
    );

    bind icache_top tb_icache_assert checks (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_addr(inst_addr),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata), .araddr(araddr),
        .arlen(arlen), .arburst(arburst), .arvalid(arvalid), .arready(arready),
        .rready(rready), .tag_we(tag_we), .wr_way(wr_way)
    );

    // galois lfsr, one step per bit
    function automatic int unsigned rand_bits(input int unsigned count);
        int unsigned value;
        value = 0;
        for (int unsigned i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // hold the request until the reply, then leave one idle cycle
    task automatic fetch(input icache_pkg::addr_t addr, input logic hit,
                         input icache_pkg::way_t way);
        DUT.checks.expect_hit = hit;
        DUT.checks.expect_way = way;
        inst_addr = addr;
        inst_req  = 1'b1;
        next_cycle();
        while (!inst_data_ok) begin
            next_cycle();
        end
        next_cycle();
        inst_req = 1'b0;
        next_cycle();
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // memory answers each beat with the inverted byte address
    initial begin : memory_model
        icache_pkg::addr_t burst_addr;
        int                burst_len;
        forever begin
            next_cycle();
            if (arvalid) begin
                repeat (rand_bits(2)) begin
                    next_cycle();
                end
                arready    = 1'b1;
                burst_addr = araddr;
                burst_len  = int'(arlen);
                next_cycle();
                arready = 1'b0;
                for (int beat = 0; beat <= burst_len; beat++) begin
                    while (rand_bits(1) == 1) begin
                        next_cycle();
                    end
                    rvalid = 1'b1;
                    rdata  = ~(burst_addr + icache_pkg::addr_t'(4 * beat));
                    rlast  = beat == burst_len;
                    next_cycle();
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin
        cycle_count++;
        if (DUT.checks.fail_count != 0) begin
            $display("test failed");
            $fatal(1, "assertion check failed at cycle %0d", cycle_count);
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("test failed");
            $fatal(1, "timeout after %0d cycles before the sequence ended", cycle_count);
        end
    end

    initial begin
        rst       = 1'b1;
        inst_req  = 1'b0;
        inst_addr = '0;
        arready   = 1'b0;
        rdata     = '0;
        rlast     = 1'b0;
        rvalid    = 1'b0;
        DUT.checks.expect_hit = 1'b0;
        DUT.checks.expect_way = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();

        // set 1: miss into way 0, then two hits in the same line
        fetch(32'h8000_0024, 1'b0, 2'd0);
        fetch(32'h8000_0038, 1'b1, 2'd0);
        fetch(32'h8000_0020, 1'b1, 2'd0);

        // uncached goes to the bus every time
        fetch(32'hA000_0100, 1'b0, 2'd0);
        fetch(32'hA000_0100, 1'b0, 2'd0);
        fetch(32'hBFC0_0004, 1'b0, 2'd0);

        // set 5: A B C D fill ways 0 2 1 3
        fetch(32'h0000_10A0, 1'b0, 2'd0);
        fetch(32'h0000_20A4, 1'b0, 2'd2);
        fetch(32'h0000_30A8, 1'b0, 2'd1);
        fetch(32'h8000_40AC, 1'b0, 2'd3);
        // hit on A, then E takes B's way
        fetch(32'h0000_10BC, 1'b1, 2'd0);
        fetch(32'h0000_50A0, 1'b0, 2'd2);
        fetch(32'h0000_10A4, 1'b1, 2'd0);
        fetch(32'h0000_20A4, 1'b0, 2'd3);
        fetch(32'h0000_30B0, 1'b1, 2'd0);

        next_cycle();
        next_cycle();
        if (DUT.checks.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "%0d assertion checks failed", DUT.checks.fail_count);
        end
    end

endmodule

`default_nettype wire

// ==== tb_icache_assert.sv ====
`default_nettype none
`include "icache_settings.svh"

module tb_icache_assert (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                inst_req,
    input wire icache_pkg::addr_t   inst_addr,
    input wire logic                inst_data_ok,
    input wire icache_pkg::word_t   inst_rdata,
    input wire icache_pkg::addr_t   araddr,
    input wire axi_pkg::axi_len_t   arlen,
    input wire axi_pkg::axi_burst_t arburst,
    input wire logic                arvalid,
    input wire logic                arready,
    input wire logic                rready,
    input wire logic                tag_we,
    input wire icache_pkg::way_t    wr_way
);
    timeunit 1ns;
    timeprecision 100ps;

    // expectations for the fetch in flight, written from the testbench
    logic             expect_hit;
    icache_pkg::way_t expect_way;
    int unsigned      fail_count = 0;
    logic [1:0]       ar_count;

    // segments 100 and 101 lose their top bits on the bus
    function automatic icache_pkg::addr_t bus_addr(input icache_pkg::addr_t addr);
        if (addr[31:29] == `SEG_UNCACHED || addr[31:29] == `SEG_MAPPED_LO) begin
            return {3'b000, addr[28:0]};
        end
        return addr;
    endfunction

    function automatic logic is_uncached(input icache_pkg::addr_t addr);
        return addr[31:29] == `SEG_UNCACHED;
    endfunction

    // address handshakes since the last reply
    always_ff @(posedge clk) begin
        if (rst || inst_data_ok) begin
            ar_count <= 2'd0;
        end else if (arvalid && arready) begin
            ar_count <= ar_count + 2'd1;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        rst |=> !arvalid && !rready && !inst_data_ok)
        else begin
            $error("bus or reply active during or right after reset");
            fail_count++;
        end

    reply_data: assert property (@(posedge clk) disable iff (rst)
        inst_data_ok |-> inst_rdata == ~bus_addr(inst_addr))
        else begin
            $error("[ERROR] inst_rdata %h expected %h", $sampled(inst_rdata),
                   ~bus_addr($sampled(inst_addr)));
            fail_count++;
        end

    ar_fields: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> (is_uncached(inst_addr) ?
            (araddr == bus_addr(inst_addr) && arlen == 8'd0 &&
             arburst == `AXI_BURST_FIXED) :
            (araddr == (bus_addr(inst_addr) & 32'hFFFF_FFE0) && arlen == 8'd7 &&
             arburst == `AXI_BURST_INCR)))
        else begin
            $error("[ERROR] araddr %h arlen %h arburst %h for inst_addr %h",
                   $sampled(araddr), $sampled(arlen), $sampled(arburst),
                   $sampled(inst_addr));
            fail_count++;
        end

    // stalled address channel holds its fields
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen) &&
                                $stable(arburst))
        else begin
            $error("address channel changed while arready was low");
            fail_count++;
        end

    hit_no_ar: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> !expect_hit)
        else begin
            $error("read address issued for a fetch that should hit");
            fail_count++;
        end

    hit_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_req) && expect_hit |=> inst_data_ok)
        else begin
            $error("hit not answered one cycle after the request");
            fail_count++;
        end

    miss_one_ar: assert property (@(posedge clk) disable iff (rst)
        inst_data_ok && !expect_hit |-> ar_count == 2'd1)
        else begin
            $error("miss answered after %0d address handshakes instead of one",
                   $sampled(ar_count));
            fail_count++;
        end

    fill_way: assert property (@(posedge clk) disable iff (rst)
        tag_we |-> wr_way == expect_way)
        else begin
            $error("[ERROR] wr_way %h expected %h", $sampled(wr_way), $sampled(expect_way));
            fail_count++;
        end

endmodule

`default_nettype wire
